/* Makefile */
TOP = tb_pid_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal -f pid_ctrl.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall -f pid_ctrl.f --top-module pid_ctrl_top

clean:
	rm -rf obj_dir sim.log

/* hdl/instr_dispatch.sv */
`timescale 1ns/1ps

module instr_dispatch #(
	parameter int N_OUT = 4,
	parameter int N_IN = 2,
	parameter int QUEUE_DEPTH = 8
) (
	input  logic                 sys_clk_in,
	input  logic                 sys_reset,
	input  pid_pkg::sample_in_t  sample_in,
	input  pid_pkg::cfg_write_t  cfg,
	output pid_pkg::instr_t      issue
);

	localparam int W_IDX = pid_pkg::idx_width(N_OUT);
	localparam int W_QP = pid_pkg::idx_width(QUEUE_DEPTH);
	localparam int W_QC = $clog2(QUEUE_DEPTH + 1);
	localparam int DEPTH = pid_pkg::PIPE_DEPTH;

	// sample queue
	logic [7:0] q_chan [QUEUE_DEPTH];
	pid_pkg::sample_t q_data [QUEUE_DEPTH];
	logic [W_QP-1:0] wr_ptr;
	logic [W_QP-1:0] rd_ptr;
	logic [W_QC-1:0] q_count;
	logic q_empty;
	logic q_full;
	logic push;
	logic pop;

	// routing and search
	logic [7:0] route [N_OUT];
	logic [N_OUT-1:0] visited;
	logic [N_OUT-1:0] match;
	logic [N_OUT-1:0] busy;
	logic [W_IDX-1:0] sel;
	logic found;
	logic go;

	// dests issued in the last DEPTH cycles
	logic [DEPTH-1:0] hist_valid;
	logic [W_IDX-1:0] hist_dest [DEPTH];

	function automatic logic [W_QP-1:0] ptr_inc(input logic [W_QP-1:0] p);
		return (p == W_QP'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	//////////////////////////////////////////////////
	// sample queue
	//////////////////////////////////////////////////

	assign q_empty = (q_count == '0);
	assign q_full = (q_count == W_QC'(QUEUE_DEPTH));
	// no back-pressure, a sample into a full queue is lost
	assign push = sample_in.valid && !q_full;
	// head retires once nothing is left to visit
	assign pop = !q_empty && !found;

	always_ff @(posedge sys_clk_in) begin
		if (push) begin
			q_chan[wr_ptr] <= sample_in.chan;
			q_data[wr_ptr] <= sample_in.data;
		end
	end

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			if (push && !pop)
				q_count <= q_count + 1'b1;
			else if (pop && !push)
				q_count <= q_count - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// routing table and priority search
	//////////////////////////////////////////////////

	// N_IN marks an output as unrouted
	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			for (int o = 0; o < N_OUT; o++)
				route[o] <= 8'(N_IN);
		end else if (cfg.valid && cfg.addr == pid_pkg::IN_SEL && cfg.chan < N_OUT) begin
			route[cfg.chan[W_IDX-1:0]] <= cfg.data[7:0];
		end
	end

	always_comb begin
		for (int o = 0; o < N_OUT; o++) begin
			match[o] = !q_empty && !visited[o] && (route[o] == q_chan[rd_ptr])
				&& (route[o] < 8'(N_IN));
		end
	end

	// descending scan so the lowest matching output wins
	always_comb begin
		found = |match;
		sel = '0;
		for (int o = N_OUT - 1; o >= 0; o--) begin
			if (match[o])
				sel = W_IDX'(o);
		end
	end

	// outputs with an instruction still in the pipeline
	always_comb begin
		busy = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (hist_valid[i])
				busy[hist_dest[i]] = 1'b1;
		end
	end

	// hold the whole sample while its next output is in flight
	assign go = found && !busy[sel];

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset)
			visited <= '0;
		else if (pop)
			visited <= '0;
		else if (go)
			visited[sel] <= 1'b1;
	end

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset)
			hist_valid <= '0;
		else
			hist_valid <= {hist_valid[DEPTH-2:0], go};
	end

	always_ff @(posedge sys_clk_in) begin
		hist_dest[0] <= sel;
		for (int i = 1; i < DEPTH; i++)
			hist_dest[i] <= hist_dest[i-1];
	end

	// issue register
	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= go;
			issue.dest <= 8'(sel);
			issue.value <= pid_pkg::pid_t'(q_data[rd_ptr]);
		end
	end

	a_no_push_full: assert property (@(posedge sys_clk_in) disable iff (sys_reset)
		sample_in.valid |-> !q_full)
		else $error("dispatch queue full, sample on chan %0d dropped", sample_in.chan);

	a_issue_dest: assert property (@(posedge sys_clk_in) disable iff (sys_reset)
		issue.valid |-> issue.dest < N_OUT)
		else $error("issued dest %0d out of range", issue.dest);

endmodule

/* hdl/opp_stage.sv */
`timescale 1ns/1ps

module opp_stage #(
	parameter int N_OUT = 4
) (
	input  logic                 sys_clk_in,
	input  logic                 sys_reset,
	input  pid_pkg::cfg_write_t  cfg,
	input  pid_pkg::instr_t      in,
	output logic                 out_valid,
	output logic [7:0]           out_chan,
	output pid_pkg::out_t        out_data
);

	localparam int W_IDX = pid_pkg::idx_width(N_OUT);
	// full product width, truncated only after the shift
	localparam int W_PROD = pid_pkg::W_PID + pid_pkg::W_COEF;

	// per-output settings and accumulator
	pid_pkg::coef_t opp_mult [N_OUT];
	pid_pkg::shift_t opp_rs [N_OUT];
	pid_pkg::out_t opp_min [N_OUT];
	pid_pkg::out_t opp_max [N_OUT];
	pid_pkg::out_t opp_prev [N_OUT];

	logic [3:1] v_pipe;
	logic [W_IDX-1:0] i_pipe [1:3];

	logic signed [W_PROD-1:0] q1_prod;
	pid_pkg::shift_t q1_rs;
	pid_pkg::out_t q2_shift;
	pid_pkg::out_t q3_hi;
	pid_pkg::out_t acc;
	pid_pkg::out_t lo;

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			for (int o = 0; o < N_OUT; o++) begin
				opp_mult[o] <= '0;
				opp_rs[o] <= '0;
				opp_min[o] <= '0;
				opp_max[o] <= '0;
			end
		end else if (cfg.valid && cfg.chan < N_OUT) begin
			case (cfg.addr)
				pid_pkg::OPP_MULT: opp_mult[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_COEF-1:0];
				pid_pkg::OPP_RS: opp_rs[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_SHIFT-1:0];
				pid_pkg::OPP_MIN: opp_min[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_OUT-1:0];
				pid_pkg::OPP_MAX: opp_max[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_OUT-1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset)
			v_pipe <= '0;
		else
			v_pipe <= {v_pipe[2:1], in.valid};
	end

	always_ff @(posedge sys_clk_in) begin
		i_pipe[1] <= in.dest[W_IDX-1:0];
		i_pipe[2] <= i_pipe[1];
		i_pipe[3] <= i_pipe[2];
	end

	//////////////////////////////////////////////////
	// scale, accumulate, clamp
	//////////////////////////////////////////////////

	// accumulate then clamp high against this channel
	assign acc = q2_shift + opp_prev[i_pipe[2]];
	assign lo = (q3_hi < opp_min[i_pipe[3]]) ? opp_min[i_pipe[3]] : q3_hi;

	always_ff @(posedge sys_clk_in) begin
		// multiply and fetch shift
		q1_prod <= W_PROD'(in.value) * W_PROD'(opp_mult[in.dest[W_IDX-1:0]]);
		q1_rs <= opp_rs[in.dest[W_IDX-1:0]];
		// arithmetic right shift down to output width
		q2_shift <= pid_pkg::out_t'(q1_prod >>> q1_rs);
		q3_hi <= (acc > opp_max[i_pipe[2]]) ? opp_max[i_pipe[2]] : acc;
	end

	// writeback and emit
	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			out_valid <= 1'b0;
			for (int o = 0; o < N_OUT; o++)
				opp_prev[o] <= '0;
		end else begin
			out_valid <= v_pipe[3];
			out_chan <= 8'(i_pipe[3]);
			out_data <= lo;
			if (v_pipe[3])
				opp_prev[i_pipe[3]] <= lo;
		end
	end

	a_out_range: assert property (@(posedge sys_clk_in) disable iff (sys_reset)
		out_valid && (opp_max[out_chan[W_IDX-1:0]] >= opp_min[out_chan[W_IDX-1:0]])
		|-> (out_data <= opp_max[out_chan[W_IDX-1:0]])
		&& (out_data >= opp_min[out_chan[W_IDX-1:0]]))
		else $error("chan %0d output %h outside limits", out_chan, out_data);

endmodule

/* hdl/osf_stage.sv */
`timescale 1ns/1ps

module osf_stage #(
	parameter int N_OUT = 4
) (
	input  logic                 sys_clk_in,
	input  logic                 sys_reset,
	input  pid_pkg::cfg_write_t  cfg,
	input  pid_pkg::instr_t      in,
	output pid_pkg::instr_t      out
);

	localparam int W_IDX = pid_pkg::idx_width(N_OUT);
	// count must reach 2^15 for the largest exponent
	localparam int W_CNT = 2 ** pid_pkg::W_OS;

	// per-output state
	pid_pkg::pid_t osf_sum [N_OUT];
	logic [W_CNT-1:0] osf_cnt [N_OUT];
	pid_pkg::os_t osf_os [N_OUT];

	// read-add results for the incoming dest
	logic [W_IDX-1:0] in_idx;
	pid_pkg::pid_t sum_nxt;
	logic [W_CNT-1:0] cnt_nxt;
	logic done_nxt;

	// first stage registers
	logic s1_valid;
	logic [7:0] s1_dest;
	logic s1_done;
	pid_pkg::pid_t s1_sum;
	pid_pkg::os_t s1_os;

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			for (int o = 0; o < N_OUT; o++)
				osf_os[o] <= '0;
		end else if (cfg.valid && cfg.addr == pid_pkg::OSF_OS && cfg.chan < N_OUT) begin
			osf_os[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_OS-1:0];
		end
	end

	//////////////////////////////////////////////////
	// stage 1, read add writeback
	//////////////////////////////////////////////////

	assign in_idx = in.dest[W_IDX-1:0];
	assign sum_nxt = osf_sum[in_idx] + in.value;
	assign cnt_nxt = osf_cnt[in_idx] + 1'b1;
	// count satisfied at 2^n, so n = 0 passes every sample
	assign done_nxt = (cnt_nxt == (W_CNT'(1) << osf_os[in_idx]));

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			for (int o = 0; o < N_OUT; o++) begin
				osf_sum[o] <= '0;
				osf_cnt[o] <= '0;
			end
		end else if (in.valid) begin
			osf_sum[in_idx] <= done_nxt ? '0 : sum_nxt;
			osf_cnt[in_idx] <= done_nxt ? '0 : cnt_nxt;
		end
	end

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in.valid;
			s1_dest <= in.dest;
			s1_done <= done_nxt;
			s1_sum <= sum_nxt;
			s1_os <= osf_os[in_idx];
		end
	end

	//////////////////////////////////////////////////
	// stage 2, divide by 2^n
	//////////////////////////////////////////////////

	// partial counts stop here
	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			out.valid <= 1'b0;
		end else begin
			out.valid <= s1_valid && s1_done;
			out.dest <= s1_dest;
			out.value <= s1_sum >>> s1_os;
		end
	end

endmodule

/* hdl/pid_ctrl_top.sv */
`timescale 1ns/1ps

module pid_ctrl_top #(
	parameter int N_OUT = 4,
	parameter int N_IN = 2
) (
	input  logic                 sys_clk_in,
	input  logic                 sys_reset,
	input  pid_pkg::sample_in_t  sample_in,
	input  pid_pkg::cfg_write_t  cfg,
	output logic                 out_valid,
	output logic [7:0]           out_chan,
	output pid_pkg::out_t        out_data
);

	//////////////////////////////////////////////////
	// pipeline links
	//////////////////////////////////////////////////

	// dispatch to oversample filter
	pid_pkg::instr_t issue;
	// oversample average to pid core
	pid_pkg::instr_t osf_out;
	// pid result to preprocessor
	pid_pkg::instr_t pid_out;

	instr_dispatch #(
		.N_OUT       (N_OUT),
		.N_IN        (N_IN)
	) instr_dispatch_inst (
		.sys_clk_in  (sys_clk_in),
		.sys_reset   (sys_reset),
		.sample_in   (sample_in),
		.cfg         (cfg),
		.issue       (issue)
	);

	osf_stage #(.N_OUT(N_OUT)) osf_stage_inst (
		.sys_clk_in  (sys_clk_in),
		.sys_reset   (sys_reset),
		.cfg         (cfg),
		.in          (issue),
		.out         (osf_out)
	);

	pid_stage #(.N_OUT(N_OUT)) pid_stage_inst (
		.sys_clk_in  (sys_clk_in),
		.sys_reset   (sys_reset),
		.cfg         (cfg),
		.in          (osf_out),
		.out         (pid_out)
	);

	// results leave on a plain valid strobe
	opp_stage #(.N_OUT(N_OUT)) opp_stage_inst (
		.sys_clk_in  (sys_clk_in),
		.sys_reset   (sys_reset),
		.cfg         (cfg),
		.in          (pid_out),
		.out_valid   (out_valid),
		.out_chan    (out_chan),
		.out_data    (out_data)
	);

endmodule

/* hdl/pid_pkg.sv */
package pid_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int W_SAMPLE = 16;
	localparam int W_COEF = 16;
	localparam int W_PID = 32;
	localparam int W_OUT = 24;
	localparam int W_SHIFT = 5;
	localparam int W_OS = 4;

	// value types
	typedef logic signed [W_SAMPLE-1:0] sample_t;
	typedef logic signed [W_COEF-1:0] coef_t;
	typedef logic signed [W_PID-1:0] pid_t;
	typedef logic signed [W_OUT-1:0] out_t;
	typedef logic [W_SHIFT-1:0] shift_t;
	typedef logic [W_OS-1:0] os_t;

	//////////////////////////////////////////////////
	// pipeline timing
	//////////////////////////////////////////////////

	localparam int OSF_LAT = 2;
	localparam int PID_LAT = 5;
	localparam int OPP_LAT = 4;
	// issue to out_valid, also the dispatcher hazard window
	localparam int PIPE_DEPTH = OSF_LAT + PID_LAT + OPP_LAT;

	// settings targets, field value sits in the low bits of data
	typedef enum logic [3:0] {
		IN_SEL   = 4'd0,
		OSF_OS   = 4'd1,
		SETPOINT = 4'd2,
		P_COEF   = 4'd3,
		I_COEF   = 4'd4,
		D_COEF   = 4'd5,
		LOCK_EN  = 4'd6,
		OPP_MULT = 4'd7,
		OPP_RS   = 4'd8,
		OPP_MIN  = 4'd9,
		OPP_MAX  = 4'd10
	} cfg_addr_e;

	typedef struct packed {
		logic valid;
		cfg_addr_e addr;
		logic [7:0] chan;
		logic [31:0] data;
	} cfg_write_t;

	typedef struct packed {
		logic valid;
		logic [7:0] dest;
		pid_t value;
	} instr_t;

	typedef struct packed {
		logic valid;
		logic [7:0] chan;
		sample_t data;
	} sample_in_t;

	// index width for a table of n entries, never zero
	function automatic int idx_width(input int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

/* hdl/pid_stage.sv */
`timescale 1ns/1ps

module pid_stage #(
	parameter int N_OUT = 4
) (
	input  logic                 sys_clk_in,
	input  logic                 sys_reset,
	input  pid_pkg::cfg_write_t  cfg,
	input  pid_pkg::instr_t      in,
	output pid_pkg::instr_t      out
);

	localparam int W_IDX = pid_pkg::idx_width(N_OUT);
	localparam int W = pid_pkg::W_PID;

	// per-output settings
	pid_pkg::coef_t set_pt [N_OUT];
	pid_pkg::coef_t kp [N_OUT];
	pid_pkg::coef_t ki [N_OUT];
	pid_pkg::coef_t kd [N_OUT];
	logic [N_OUT-1:0] lock_en;
	// per-output history
	pid_pkg::pid_t err1 [N_OUT];
	pid_pkg::pid_t err2 [N_OUT];
	pid_pkg::pid_t prev [N_OUT];

	// valid and dest travel alongside stages 1 to 4
	logic [4:1] v_pipe;
	logic [7:0] d_pipe [1:4];
	logic [4:1] l_pipe;

	pid_pkg::pid_t p1_in, p1_e1, p1_e2, p1_prev;
	pid_pkg::coef_t p1_set, p1_kp, p1_ki, p1_kd;
	pid_pkg::pid_t p2_err, p2_k1, p2_k2, p2_k3, p2_e1, p2_e2, p2_prev;
	pid_pkg::pid_t p3_prod0, p3_prod1, p3_prod2, p3_prev;
	pid_pkg::pid_t p4_delta, p4_prev;
	pid_pkg::pid_t sum;
	pid_pkg::pid_t result;
	logic ovf;

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			for (int o = 0; o < N_OUT; o++) begin
				set_pt[o] <= '0;
				kp[o] <= '0;
				ki[o] <= '0;
				kd[o] <= '0;
			end
			lock_en <= '0;
		end else if (cfg.valid && cfg.chan < N_OUT) begin
			case (cfg.addr)
				pid_pkg::SETPOINT: set_pt[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_COEF-1:0];
				pid_pkg::P_COEF: kp[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_COEF-1:0];
				pid_pkg::I_COEF: ki[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_COEF-1:0];
				pid_pkg::D_COEF: kd[cfg.chan[W_IDX-1:0]] <= cfg.data[pid_pkg::W_COEF-1:0];
				pid_pkg::LOCK_EN: lock_en[cfg.chan[W_IDX-1:0]] <= cfg.data[0];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// control pipe
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			v_pipe <= '0;
		end else begin
			v_pipe <= {v_pipe[3:1], in.valid};
		end
	end

	always_ff @(posedge sys_clk_in) begin
		d_pipe[1] <= in.dest;
		l_pipe[1] <= lock_en[in.dest[W_IDX-1:0]];
		for (int i = 2; i <= 4; i++) begin
			d_pipe[i] <= d_pipe[i-1];
			l_pipe[i] <= l_pipe[i-1];
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	always_ff @(posedge sys_clk_in) begin
		// fetch settings and history
		p1_in <= in.value;
		p1_set <= set_pt[in.dest[W_IDX-1:0]];
		p1_kp <= kp[in.dest[W_IDX-1:0]];
		p1_ki <= ki[in.dest[W_IDX-1:0]];
		p1_kd <= kd[in.dest[W_IDX-1:0]];
		p1_e1 <= err1[in.dest[W_IDX-1:0]];
		p1_e2 <= err2[in.dest[W_IDX-1:0]];
		p1_prev <= prev[in.dest[W_IDX-1:0]];
		// error and z-transform coefficients
		p2_err <= W'(p1_set) - p1_in;
		p2_k1 <= W'(p1_kp) + W'(p1_ki) + W'(p1_kd);
		p2_k2 <= -W'(p1_kp) - (W'(p1_kd) <<< 1);
		p2_k3 <= W'(p1_kd);
		p2_e1 <= p1_e1;
		p2_e2 <= p1_e2;
		p2_prev <= p1_prev;
		// coefficient error products
		p3_prod0 <= p2_k1 * p2_err;
		p3_prod1 <= p2_k2 * p2_e1;
		p3_prod2 <= p2_k3 * p2_e2;
		p3_prev <= p2_prev;
		// delta
		p4_delta <= p3_prod0 + p3_prod1 + p3_prod2;
		p4_prev <= p3_prev;
	end

	// shift error history, cleared while unlocked
	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			for (int o = 0; o < N_OUT; o++) begin
				err1[o] <= '0;
				err2[o] <= '0;
			end
		end else if (v_pipe[2]) begin
			err1[d_pipe[2][W_IDX-1:0]] <= l_pipe[2] ? p2_err : '0;
			err2[d_pipe[2][W_IDX-1:0]] <= l_pipe[2] ? p2_e1 : '0;
		end
	end

	// overflow when both operands share a sign the sum lost
	assign sum = p4_prev + p4_delta;
	assign ovf = (p4_prev[W-1] == p4_delta[W-1]) && (sum[W-1] != p4_prev[W-1]);

	always_comb begin
		if (!l_pipe[4])
			result = '0;
		else if (ovf)
			result = p4_prev[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
		else
			result = sum;
	end

	always_ff @(posedge sys_clk_in) begin
		if (sys_reset) begin
			out.valid <= 1'b0;
			for (int o = 0; o < N_OUT; o++)
				prev[o] <= '0;
		end else begin
			out.valid <= v_pipe[4];
			out.dest <= d_pipe[4];
			out.value <= result;
			if (v_pipe[4])
				prev[d_pipe[4][W_IDX-1:0]] <= result;
		end
	end

	a_out_dest: assert property (@(posedge sys_clk_in) disable iff (sys_reset)
		out.valid |-> out.dest < N_OUT)
		else $error("pid result for dest %0d out of range", out.dest);

endmodule

/* pid_ctrl.f */
+incdir+tb
hdl/pid_pkg.sv
hdl/instr_dispatch.sv
hdl/osf_stage.sv
hdl/pid_stage.sv
hdl/opp_stage.sv
hdl/pid_ctrl_top.sv
tb/tb_pid_ctrl.sv

/* tb/tb_pid_ctrl_vectors.svh */
// cfg_entry: test, settings address, output, data word
// smp_entry: test, input, sample; rnd_entry: test, input with a random sample
// burst_entry: test, input with a random sample and no idle gap behind it

// nothing routed, no result expected
smp_entry(1, 0, 32'd100);
smp_entry(1, 1, 32'hffff_ff00);
smp_entry(1, 5, 32'd7);

// input 0 fans out to outputs 1 and 3, input 1 to output 0
cfg_entry(2, pid_pkg::IN_SEL, 1, 32'd0);
cfg_entry(2, pid_pkg::IN_SEL, 3, 32'd0);
cfg_entry(2, pid_pkg::IN_SEL, 0, 32'd1);
identity_setup(2, 0);
identity_setup(2, 1);
identity_setup(2, 3);
smp_entry(2, 0, 32'd100);
smp_entry(2, 1, 32'hffff_ffce);
smp_entry(2, 0, 32'd7);

// four-sample averaging on output 0
cfg_entry(3, pid_pkg::OSF_OS, 0, 32'd2);
smp_entry(3, 1, 32'd10);
smp_entry(3, 1, 32'd20);
smp_entry(3, 1, 32'd30);
smp_entry(3, 1, 32'd41);
smp_entry(3, 1, 32'hffff_fffc);
smp_entry(3, 1, 32'hffff_fffc);
smp_entry(3, 1, 32'hffff_fffc);
smp_entry(3, 1, 32'hffff_fffd);

// full PID terms, then unlocked, then integral run into saturation
cfg_entry(4, pid_pkg::OSF_OS, 0, 32'd0);
cfg_entry(4, pid_pkg::SETPOINT, 0, 32'd1000);
cfg_entry(4, pid_pkg::P_COEF, 0, 32'd3);
cfg_entry(4, pid_pkg::I_COEF, 0, 32'd2);
cfg_entry(4, pid_pkg::D_COEF, 0, 32'd1);
for (int k = 0; k < 6; k++)
	rnd_entry(4, 1);
cfg_entry(4, pid_pkg::LOCK_EN, 0, 32'd0);
smp_entry(4, 1, 32'd500);
cfg_entry(4, pid_pkg::LOCK_EN, 0, 32'd1);
cfg_entry(4, pid_pkg::P_COEF, 0, 32'd0);
cfg_entry(4, pid_pkg::D_COEF, 0, 32'd0);
cfg_entry(4, pid_pkg::I_COEF, 0, 32'h4000);
cfg_entry(4, pid_pkg::SETPOINT, 0, 32'h7fff);
cfg_entry(4, pid_pkg::OPP_RS, 0, 32'd8);
for (int k = 0; k < 4; k++)
	smp_entry(4, 1, 32'hffff_8001);

// output 2 scales by 3/2 and clamps to -200..300
cfg_entry(5, pid_pkg::IN_SEL, 2, 32'd1);
identity_setup(5, 2);
cfg_entry(5, pid_pkg::OPP_MULT, 2, 32'd3);
cfg_entry(5, pid_pkg::OPP_RS, 2, 32'd1);
cfg_entry(5, pid_pkg::OPP_MIN, 2, 32'hffff_ff38);
cfg_entry(5, pid_pkg::OPP_MAX, 2, 32'd300);
smp_entry(5, 1, 32'd100);
smp_entry(5, 1, 32'hffff_fe70);
smp_entry(5, 1, 32'hffff_fe70);
smp_entry(5, 1, 32'd500);
smp_entry(5, 1, 32'd500);

// bursts of three on input 0, same outputs while still in flight
for (int k = 0; k < 2; k++) begin
	burst_entry(6, 0);
	burst_entry(6, 0);
	rnd_entry(6, 0);
end

/* tb/tb_pid_ctrl.sv */
`timescale 1ns/1ps

module tb_pid_ctrl;

	localparam int N_OUT = 4;
	localparam int N_IN = 2;
	localparam int DEPTH = pid_pkg::PIPE_DEPTH;
	// cycles a drain may wait for outstanding results
	localparam int DRAIN_MAX = 200;

	logic sys_clk_in;
	logic sys_reset;
	pid_pkg::sample_in_t sample_in;
	pid_pkg::cfg_write_t cfg;
	logic out_valid;
	logic [7:0] out_chan;
	pid_pkg::out_t out_data;

	// stimulus table
	int ent_test[$];
	bit ent_smp[$];
	// idle cycles follow this sample
	bit ent_gap[$];
	pid_pkg::cfg_addr_e ent_addr[$];
	logic [7:0] ent_chan[$];
	logic [31:0] ent_data[$];
	integer seed;

	// reference model state, one slot per output
	logic [7:0] m_route [N_OUT];
	pid_pkg::os_t m_os [N_OUT];
	pid_pkg::pid_t m_sum [N_OUT];
	int m_cnt [N_OUT];
	pid_pkg::coef_t m_set [N_OUT];
	pid_pkg::coef_t m_kp [N_OUT];
	pid_pkg::coef_t m_ki [N_OUT];
	pid_pkg::coef_t m_kd [N_OUT];
	bit m_lock [N_OUT];
	pid_pkg::pid_t m_e1 [N_OUT];
	pid_pkg::pid_t m_e2 [N_OUT];
	pid_pkg::pid_t m_prev [N_OUT];
	pid_pkg::coef_t m_mult [N_OUT];
	pid_pkg::shift_t m_rs [N_OUT];
	pid_pkg::out_t m_min [N_OUT];
	pid_pkg::out_t m_max [N_OUT];
	pid_pkg::out_t m_oprev [N_OUT];

	// expected results, per channel and in arrival order
	pid_pkg::out_t exp_q [N_OUT][$];
	int exp_order[$];

	int checks;
	int errors;
	int t_checks;
	int t_errors;
	int cycles;
	int limit;
	bit pending;
	bit mon_ok;
	pid_pkg::out_t mon_exp;
	int mon_ord;

	pid_ctrl_top #(.N_OUT(N_OUT), .N_IN(N_IN)) pid_ctrl_top_inst (
		.sys_clk_in  (sys_clk_in),
		.sys_reset   (sys_reset),
		.sample_in   (sample_in),
		.cfg         (cfg),
		.out_valid   (out_valid),
		.out_chan    (out_chan),
		.out_data    (out_data)
	);

	initial begin
		sys_clk_in = 1'b0;
		forever #10 sys_clk_in = ~sys_clk_in;
	end

	//////////////////////////////////////////////////
	// table building
	//////////////////////////////////////////////////

	task automatic cfg_entry(input int t, input pid_pkg::cfg_addr_e a, input int c,
		input logic [31:0] d);
		ent_test.push_back(t);
		ent_smp.push_back(1'b0);
		ent_gap.push_back(1'b0);
		ent_addr.push_back(a);
		ent_chan.push_back(8'(c));
		ent_data.push_back(d);
	endtask

	task automatic smp_entry(input int t, input int c, input logic [31:0] d);
		ent_test.push_back(t);
		ent_smp.push_back(1'b1);
		ent_gap.push_back(1'b1);
		ent_addr.push_back(pid_pkg::IN_SEL);
		ent_chan.push_back(8'(c));
		ent_data.push_back(d);
	endtask

	task automatic rnd_entry(input int t, input int c);
		smp_entry(t, c, $random(seed));
	endtask

	// random sample with the next entry right behind it
	task automatic burst_entry(input int t, input int c);
		ent_test.push_back(t);
		ent_smp.push_back(1'b1);
		ent_gap.push_back(1'b0);
		ent_addr.push_back(pid_pkg::IN_SEL);
		ent_chan.push_back(8'(c));
		ent_data.push_back($random(seed));
	endtask

	// P of 1, lock on, unity scaling and full-range limits
	task automatic identity_setup(input int t, input int o);
		cfg_entry(t, pid_pkg::P_COEF, o, 32'd1);
		cfg_entry(t, pid_pkg::LOCK_EN, o, 32'd1);
		cfg_entry(t, pid_pkg::OPP_MULT, o, 32'd1);
		cfg_entry(t, pid_pkg::OPP_MIN, o, 32'hff80_0000);
		cfg_entry(t, pid_pkg::OPP_MAX, o, 32'h007f_ffff);
	endtask

	task automatic build_table;
		`include "tb_pid_ctrl_vectors.svh"
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	task automatic model_cfg(input pid_pkg::cfg_addr_e a, input logic [7:0] c,
		input logic [31:0] d);
		if (c < N_OUT) begin
			case (a)
				pid_pkg::IN_SEL: m_route[c] = d[7:0];
				pid_pkg::OSF_OS: m_os[c] = d[3:0];
				pid_pkg::SETPOINT: m_set[c] = d[15:0];
				pid_pkg::P_COEF: m_kp[c] = d[15:0];
				pid_pkg::I_COEF: m_ki[c] = d[15:0];
				pid_pkg::D_COEF: m_kd[c] = d[15:0];
				pid_pkg::LOCK_EN: m_lock[c] = d[0];
				pid_pkg::OPP_MULT: m_mult[c] = d[15:0];
				pid_pkg::OPP_RS: m_rs[c] = d[4:0];
				pid_pkg::OPP_MIN: m_min[c] = d[23:0];
				pid_pkg::OPP_MAX: m_max[c] = d[23:0];
				default: ;
			endcase
		end
	endtask

	// velocity-form step then scale, accumulate and clamp
	task automatic model_pid_opp(input int o, input pid_pkg::pid_t v);
		pid_pkg::pid_t err;
		pid_pkg::pid_t k1;
		pid_pkg::pid_t k2;
		pid_pkg::pid_t k3;
		pid_pkg::pid_t delta;
		longint wide;
		pid_pkg::pid_t res;
		logic signed [47:0] prod;
		pid_pkg::out_t acc;
		err = pid_pkg::pid_t'(m_set[o]) - v;
		k1 = pid_pkg::pid_t'(m_kp[o]) + pid_pkg::pid_t'(m_ki[o]) + pid_pkg::pid_t'(m_kd[o]);
		k2 = -pid_pkg::pid_t'(m_kp[o]) - 2 * pid_pkg::pid_t'(m_kd[o]);
		k3 = pid_pkg::pid_t'(m_kd[o]);
		delta = k1 * err + k2 * m_e1[o] + k3 * m_e2[o];
		wide = longint'(m_prev[o]) + longint'(delta);
		if (!m_lock[o]) begin
			res = 0;
			m_e1[o] = 0;
			m_e2[o] = 0;
		end else begin
			// true sum outside the pid_t range pins to the limit
			if (wide > longint'(32'sh7fff_ffff))
				res = 32'sh7fff_ffff;
			else if (wide < longint'(32'sh8000_0000))
				res = 32'sh8000_0000;
			else
				res = pid_pkg::pid_t'(wide);
			m_e2[o] = m_e1[o];
			m_e1[o] = err;
		end
		m_prev[o] = res;
		prod = res * m_mult[o];
		acc = pid_pkg::out_t'(prod >>> m_rs[o]) + m_oprev[o];
		if (acc > m_max[o])
			acc = m_max[o];
		if (acc < m_min[o])
			acc = m_min[o];
		m_oprev[o] = acc;
		exp_q[o].push_back(acc);
		exp_order.push_back(o);
	endtask

	task automatic model_sample(input logic [7:0] c, input pid_pkg::sample_t d);
		pid_pkg::pid_t avg;
		for (int o = 0; o < N_OUT; o++) begin
			if (m_route[o] == c && m_route[o] < N_IN) begin
				m_sum[o] = m_sum[o] + pid_pkg::pid_t'(d);
				m_cnt[o]++;
				// average only when 2^n samples are in
				if (m_cnt[o] == (1 << m_os[o])) begin
					avg = m_sum[o] >>> m_os[o];
					m_sum[o] = 0;
					m_cnt[o] = 0;
					model_pid_opp(o, avg);
				end
			end
		end
	endtask

	task automatic model_reset;
		for (int o = 0; o < N_OUT; o++) begin
			m_route[o] = 8'(N_IN);
			m_os[o] = '0;
			m_sum[o] = '0;
			m_cnt[o] = 0;
			m_set[o] = '0;
			m_kp[o] = '0;
			m_ki[o] = '0;
			m_kd[o] = '0;
			m_lock[o] = 1'b0;
			m_e1[o] = '0;
			m_e2[o] = '0;
			m_prev[o] = '0;
			m_mult[o] = '0;
			m_rs[o] = '0;
			m_min[o] = '0;
			m_max[o] = '0;
			m_oprev[o] = '0;
		end
	endtask

	//////////////////////////////////////////////////
	// drive and drain
	//////////////////////////////////////////////////

	// wait out every expected result, then let the pipe empty
	task automatic drain_pipeline;
		int waited;
		waited = 0;
		while (exp_order.size() > 0 && waited < DRAIN_MAX) begin
			@(negedge sys_clk_in);
			waited++;
		end
		assert (exp_order.size() == 0) else begin
			$display("%0d expected results never arrived", exp_order.size());
			errors++;
			t_errors++;
			exp_order.delete();
			for (int o = 0; o < N_OUT; o++)
				exp_q[o].delete();
		end
		repeat (2 * DEPTH) @(posedge sys_clk_in);
		pending = 1'b0;
	endtask

	task automatic apply_entry(input int i);
		if (!ent_smp[i] && pending)
			drain_pipeline();
		@(posedge sys_clk_in);
		#2;
		if (ent_smp[i]) begin
			sample_in.valid = 1'b1;
			sample_in.chan = ent_chan[i];
			sample_in.data = ent_data[i][15:0];
			model_sample(ent_chan[i], ent_data[i][15:0]);
			pending = 1'b1;
		end else begin
			cfg.valid = 1'b1;
			cfg.addr = ent_addr[i];
			cfg.chan = ent_chan[i];
			cfg.data = ent_data[i];
			model_cfg(ent_addr[i], ent_chan[i], ent_data[i]);
		end
		@(posedge sys_clk_in);
		#2;
		sample_in.valid = 1'b0;
		cfg.valid = 1'b0;
		// idle gap keeps the queue from filling, bursts go without it
		if (ent_smp[i] && ent_gap[i])
			repeat (N_OUT + 1) @(posedge sys_clk_in);
	endtask

	task automatic report_test(input int t);
		drain_pipeline();
		$display("test %0d done, %0d results checked, %0d errors", t, t_checks, t_errors);
		t_checks = 0;
		t_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// output monitor
	//////////////////////////////////////////////////

	always @(negedge sys_clk_in) begin
		if (!sys_reset && out_valid) begin
			mon_ok = (out_chan < N_OUT);
			if (mon_ok)
				mon_ok = (exp_q[out_chan].size() > 0);
			assert (mon_ok) else begin
				$display("unexpected result %h on output %0d", out_data, out_chan);
				errors++;
				t_errors++;
			end
			if (mon_ok) begin
				mon_exp = exp_q[out_chan].pop_front();
				mon_ord = exp_order.pop_front();
				checks++;
				t_checks++;
				assert (out_chan == 8'(mon_ord)) else begin
					$display("ERR out_chan expected %h got %h", 8'(mon_ord), out_chan);
					errors++;
					t_errors++;
				end
				assert (out_data == mon_exp) else begin
					$display("ERR out_data expected %h got %h", mon_exp, out_data);
					errors++;
					t_errors++;
				end
			end
		end
	end

	// run limit from table length
	always @(posedge sys_clk_in) begin
		cycles++;
		if (cycles > limit) begin
			$display("run stopped by timeout after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		int cur;
		sys_reset = 1'b1;
		sample_in = '0;
		cfg = '0;
		checks = 0;
		errors = 0;
		t_checks = 0;
		t_errors = 0;
		cycles = 0;
		pending = 1'b0;
		seed = 32'h37e8_24fe;
		build_table();
		limit = ent_test.size() * (DEPTH + N_OUT + 4) + 100;
		model_reset();
		repeat (2) @(posedge sys_clk_in);
		#2;
		sys_reset = 1'b0;
		@(negedge sys_clk_in);
		assert (!out_valid) else begin
			$display("out_valid high right after reset");
			errors++;
		end
		cur = ent_test[0];
		for (int i = 0; i < ent_test.size(); i++) begin
			if (ent_test[i] != cur) begin
				report_test(cur);
				cur = ent_test[i];
			end
			apply_entry(i);
		end
		report_test(cur);
		$display("%0d results checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule
